/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_access_control
FILELIST  := upsp_ac.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and search the log for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_access_control.sv */
/*
 Testbench of the access controller: applies a table of frames to the
 up-sampler write port, models the control register and scores the stream.
*/
module tb_access_control
	import ac_pkg::*;
();

	localparam int img_w           = 8;
	localparam int img_h           = 3;
	localparam int frame_px        = img_w * img_h;
	localparam int n_frames        = 3;
	localparam int n_strays        = 3;
	localparam int watchdog_cycles = n_frames * frame_px * 20 + 200;

	// Junk pixels before start, tready percentage, first pixel value
	typedef struct packed {
		int     junk;
		int     ready_pct;
		pixel_t base;
	} frame_row_t;

	logic      clk           = 1'b0;
	logic      rst_n;
	logic      up_start      = 1'b0;
	logic      up_end        = 1'b0;
	crf_wr_t   crf_wr;
	logic      processing;
	logic      upsp_wvalid;
	pixel_t    upsp_wdata;
	logic      upsp_wready;
	logic      m_axis_tready = 1'b0;
	axis_out_t m_axis;

	frame_row_t frame_table [n_frames];
	pixel_t     expected_q [$];
	int         ready_pct   = 100;
	logic       host_start;
	logic       data_phase;
	int         frame_beats = 0;
	int         total_beats = 0;
	int         wr_count    = 0;
	logic       prev_stall  = 1'b0;
	axis_out_t  prev_beat;

	access_control #(
		.dst_img_width  (img_w),
		.dst_img_height (img_h),
		.out_fifo_depth (8)
	) dut0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.up_start      (up_start),
		.up_end        (up_end),
		.crf_wr        (crf_wr),
		.processing    (processing),
		.upsp_wvalid   (upsp_wvalid),
		.upsp_wdata    (upsp_wdata),
		.upsp_wready   (upsp_wready),
		.m_axis_tready (m_axis_tready),
		.m_axis        (m_axis)
	);

	always #2 clk = ~clk;

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("STATUS: FAIL");
		$fatal(1, "testbench stopped on the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			report_failure($sformatf("MISMATCH %s: expected 0x%0h actual 0x%0h",
				name, expected, actual));
		end
	endtask

	// Stream byte order is the reverse of the up-sampler word
	function automatic pixel_t byte_swap(input pixel_t p);
		return {p[7:0], p[15:8], p[23:16], p[31:24]};
	endfunction

	// Control register, set by the host or by a write-back from the DUT
	always @(posedge clk) begin
		if (crf_wr.wrt && crf_wr.addr == crf_ctrl_addr) begin
			up_start <= crf_wr.data[crf_start_bit];
			up_end   <= crf_wr.data[crf_end_bit];
		end else if (host_start) begin
			up_start <= 1'b1;
			up_end   <= 1'b0;
		end
	end

	// Sink back-pressure at the current frame's tready percentage
	initial begin : sink_ready
		void'($urandom(32'h374d_f712));
		forever begin
			@(posedge clk);
			m_axis_tready <= ($urandom_range(0, 99) < ready_pct);
		end
	end

	// Scoreboard for pixels in, beats out and register writes
	always @(posedge clk) begin : scoreboard
		pixel_t exp_word;
		if (rst_n) begin
			if (host_start) begin
				frame_beats = 0;
				wr_count    = 0;
			end
			if (data_phase && upsp_wvalid && upsp_wready) begin
				expected_q.push_back(byte_swap(upsp_wdata));
			end
			if (prev_stall) begin
				check_value("m_axis.tvalid held", 64'(1'b1), 64'(m_axis.tvalid));
				check_value("m_axis.tdata held", 64'(prev_beat.tdata), 64'(m_axis.tdata));
				check_value("m_axis.tlast held", 64'(prev_beat.tlast), 64'(m_axis.tlast));
			end
			if (m_axis.tvalid && m_axis_tready) begin
				if (expected_q.size() == 0) begin
					report_failure("A stream beat came out with no pixel written inside the window");
				end else begin
					exp_word = expected_q.pop_front();
					check_value("m_axis.tdata", 64'(exp_word), 64'(m_axis.tdata));
					check_value("m_axis.tkeep", 64'h0f, 64'(m_axis.tkeep));
					check_value("m_axis.tstrb", 64'h0f, 64'(m_axis.tstrb));
					check_value("m_axis.tlast", 64'((frame_beats % img_w) == img_w - 1),
						64'(m_axis.tlast));
					frame_beats++;
					total_beats++;
				end
			end
			prev_stall = m_axis.tvalid && !m_axis_tready;
			prev_beat  = m_axis;
			if (crf_wr.wrt) begin
				check_value("crf_wr.addr", 64'(crf_ctrl_addr), 64'(crf_wr.addr));
				if (wr_count == 0) begin
					check_value("beats before write-back", 64'(frame_px), 64'(frame_beats));
					check_value("crf_wr.data", 64'h0, 64'(crf_wr.data));
				end else begin
					check_value("crf_wr.data", 64'h2, 64'(crf_wr.data));
				end
				wr_count++;
			end
		end
	end

	initial begin
		int f;
		int i;
		rst_n          = 1'b0;
		upsp_wvalid    = 1'b0;
		upsp_wdata     = '0;
		host_start     = 1'b0;
		data_phase     = 1'b0;
		frame_table[0] = '{junk: 5, ready_pct: 100, base: 32'h1122_3300};
		frame_table[1] = '{junk: 3, ready_pct: 30, base: 32'ha0b1_c200};
		frame_table[2] = '{junk: 0, ready_pct: 65, base: 32'h5e6f_7000};
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		for (f = 0; f < n_frames; f++) begin
			ready_pct = frame_table[f].ready_pct;
			// Junk offered while the window is still closed
			for (i = 0; i < frame_table[f].junk; i++) begin
				@(posedge clk);
				check_value("processing", 64'h0, 64'(processing));
				check_value("m_axis.tvalid", 64'h0, 64'(m_axis.tvalid));
				check_value("crf_wr.wrt", 64'h0, 64'(crf_wr.wrt));
				upsp_wvalid <= 1'b1;
				upsp_wdata  <= 32'hdead_0000 | 32'(i);
			end
			@(posedge clk);
			upsp_wvalid <= 1'b0;
			host_start  <= 1'b1;
			@(posedge clk);
			host_start <= 1'b0;
			while (!processing) @(posedge clk);
			data_phase <= 1'b1;
			for (i = 0; i < frame_px; i++) begin
				upsp_wvalid <= 1'b1;
				upsp_wdata  <= frame_table[f].base + 32'(i);
				@(posedge clk);
				while (!upsp_wready) @(posedge clk);
			end
			upsp_wvalid <= 1'b0;
			data_phase  <= 1'b0;
			while (processing) @(posedge clk);
			check_value("beats in frame", 64'(frame_px), 64'(frame_beats));
			check_value("crf_wr writes in frame", 64'd2, 64'(wr_count));
			// Pixels after the frame end must stay off the stream
			for (i = 0; i < n_strays; i++) begin
				upsp_wvalid <= 1'b1;
				upsp_wdata  <= 32'hbad0_0000 | 32'(i);
				@(posedge clk);
			end
			upsp_wvalid <= 1'b0;
		end
		repeat (4) @(posedge clk);
		if (total_beats != n_frames * frame_px || expected_q.size() != 0) begin
			report_failure("The number of stream beats at the end of the run is wrong");
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		report_failure($sformatf("The run timed out after %0d cycles", watchdog_cycles));
	end

endmodule

/* src/ac_out_fifo.sv */
/*
 Output pixel FIFO between the up-sampler and the stream master.
 Writes are taken only inside the window; read data is registered on rd.
*/
module ac_out_fifo
	import ac_pkg::*;
#(
	parameter int depth = 32
) (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   flush,
	input  logic   wvalid,
	input  logic   window,
	input  pixel_t wdata,
	output logic   wready,
	input  logic   rd,
	output pixel_t rdata,
	output logic   empty
);

	localparam int ptr_w = $clog2(depth);

	typedef logic [ptr_w-1:0] ptr_t;
	typedef logic [ptr_w:0]   count_t;

	pixel_t mem [depth];
	ptr_t   wr_ptr;
	ptr_t   rd_ptr;
	count_t count;
	logic   wr_en;

	assign wready = (count != count_t'(depth));
	assign empty  = (count == '0);

	// Pixels offered outside the window are dropped here
	assign wr_en = wvalid & window & wready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			// End of frame, start the next one from an empty buffer
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (wr_en && !rd) begin
				count <= count + 1'b1;
			end else if (!wr_en && rd) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wdata;
		end
	end

	// Head word stays on rdata until the next pop
	always_ff @(posedge clk) begin
		if (rd) begin
			rdata <= mem[rd_ptr];
		end
	end

endmodule

/* src/ac_pkg.sv */
/*
 Shared widths, types and bus structs of the up-sampler access controller.
 Every RTL module of the output path imports this package.
*/
package ac_pkg;

	// Register file bus
	typedef logic [31:0] crf_data_t;
	typedef logic [31:0] crf_addr_t;

	// One pixel word per stream beat
	typedef logic [31:0] pixel_t;
	typedef logic [3:0]  keep_t;

	// Control register and its flag positions
	localparam crf_addr_t crf_ctrl_addr = 32'h0000_0000;
	localparam int        crf_start_bit = 0;
	localparam int        crf_end_bit   = 1;

	// Register write issued by the controller
	typedef struct packed {
		logic      wrt;
		crf_addr_t addr;
		crf_data_t data;
	} crf_wr_t;

	// Master stream outputs, tready comes back separately
	typedef struct packed {
		logic   tvalid;
		pixel_t tdata;
		keep_t  tkeep;
		keep_t  tstrb;
		logic   tlast;
	} axis_out_t;

endpackage

/* src/ac_session_ctrl.sv */
/*
 Session control beside the datapath: tracks processing and the write window
 from the start/end register levels and writes the end handshake back.
*/
module ac_session_ctrl
	import ac_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    up_start,
	input  logic    up_end,
	input  logic    frame_done,
	output logic    processing,
	output logic    window,
	output crf_wr_t crf_wr
);

	logic      start_req;
	logic      close_req;
	logic      end_req;
	logic      wr_q;
	crf_data_t wr_data_d;
	crf_data_t wr_data_q;
	crf_data_t end_data;

	assign start_req = up_start & ~up_end & ~processing;
	// Last beat of the frame went out while the start flag is still set
	assign close_req = processing & frame_done & up_start;
	// Start already cleared by the first write, now raise end
	assign end_req   = processing & ~up_start & ~up_end;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			processing <= 1'b0;
		end else if (start_req) begin
			processing <= 1'b1;
		end else if (~up_start & up_end & processing) begin
			processing <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			window <= 1'b0;
		end else if (start_req) begin
			window <= 1'b1;
		end else if (close_req) begin
			window <= 1'b0;
		end
	end

	// First write-back clears start and keeps the end level
	always_comb begin
		wr_data_d = '0;
		wr_data_d[crf_end_bit] = up_end;
	end

	// Second write-back raises end with start still clear
	always_comb begin
		end_data = '0;
		end_data[crf_end_bit] = 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_q <= 1'b0;
		end else begin
			wr_q <= close_req;
		end
	end

	always_ff @(posedge clk) begin
		if (close_req) begin
			wr_data_q <= wr_data_d;
		end
	end

	// End write goes out in the cycle the cleared levels are seen
	assign crf_wr = '{
		wrt:  wr_q | end_req,
		addr: crf_ctrl_addr,
		data: end_req ? end_data : wr_data_q
	};

endmodule

/* src/ac_stream_out.sv */
/*
 AXI-Stream master stage: pops the output FIFO under back-pressure, marks
 row ends with tlast and flags the completed last beat of each frame.
*/
module ac_stream_out
	import ac_pkg::*;
#(
	parameter int dst_img_width  = 4096,
	parameter int dst_img_height = 2160
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      window,
	input  logic      empty,
	input  pixel_t    rdata,
	output logic      rd,
	input  logic      tready,
	output axis_out_t m_axis,
	output logic      frame_done
);

	localparam int frame_words = dst_img_width * dst_img_height;
	localparam int cnt_w       = $clog2(frame_words + 1);
	localparam int col_w       = (dst_img_width > 1) ? $clog2(dst_img_width) : 1;
	localparam int n_bytes     = $bits(pixel_t) / 8;
	localparam keep_t all_bytes = '1;

	typedef logic [cnt_w-1:0] word_cnt_t;
	typedef logic [col_w-1:0] col_t;

	word_cnt_t word_cnt;
	col_t      col;
	logic      row_end;
	logic      beat_done;
	logic      tvalid_q;
	logic      tlast_q;
	pixel_t    tdata;

	assign beat_done = tvalid_q & tready;
	// Output register is free or empties this cycle
	assign rd        = ~empty & window & (~tvalid_q | tready);
	assign row_end   = (col == col_t'(dst_img_width - 1));
	assign frame_done = beat_done & tlast_q & (word_cnt == word_cnt_t'(frame_words));

	// Words read in this frame and position of the next word in its row
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			word_cnt <= '0;
			col      <= '0;
		end else if (frame_done) begin
			word_cnt <= '0;
			col      <= '0;
		end else if (rd) begin
			word_cnt <= word_cnt + 1'b1;
			col      <= row_end ? '0 : col + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tvalid_q <= 1'b0;
			tlast_q  <= 1'b0;
		end else if (~tvalid_q | tready) begin
			tvalid_q <= rd;
			tlast_q  <= rd & row_end;
		end
	end

	// Byte order reversed toward the stream
	always_comb begin
		for (int i = 0; i < n_bytes; i++) begin
			tdata[i*8 +: 8] = rdata[(n_bytes - 1 - i)*8 +: 8];
		end
	end

	assign m_axis = '{
		tvalid: tvalid_q,
		tdata:  tdata,
		tkeep:  all_bytes,
		tstrb:  all_bytes,
		tlast:  tlast_q
	};

endmodule

/* src/access_control.sv */
/*
 Access controller of the image up-sampler: session control, output FIFO
 and AXI-Stream master. Frame size and FIFO depth are set here.
*/
module access_control
	import ac_pkg::*;
#(
	parameter int dst_img_width  = 4096,
	parameter int dst_img_height = 2160,
	parameter int out_fifo_depth = 32
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      up_start,
	input  logic      up_end,
	output crf_wr_t   crf_wr,
	output logic      processing,
	input  logic      upsp_wvalid,
	input  pixel_t    upsp_wdata,
	output logic      upsp_wready,
	input  logic      m_axis_tready,
	output axis_out_t m_axis
);

	logic   window;
	logic   frame_done;
	logic   fifo_rd;
	logic   fifo_empty;
	pixel_t fifo_rdata;

	ac_session_ctrl u_session (
		.clk        (clk),
		.rst_n      (rst_n),
		.up_start   (up_start),
		.up_end     (up_end),
		.frame_done (frame_done),
		.processing (processing),
		.window     (window),
		.crf_wr     (crf_wr)
	);

	// Flushed on the completed last beat of every frame
	ac_out_fifo #(
		.depth (out_fifo_depth)
	) u_fifo (
		.clk    (clk),
		.rst_n  (rst_n),
		.flush  (frame_done),
		.wvalid (upsp_wvalid),
		.window (window),
		.wdata  (upsp_wdata),
		.wready (upsp_wready),
		.rd     (fifo_rd),
		.rdata  (fifo_rdata),
		.empty  (fifo_empty)
	);

	ac_stream_out #(
		.dst_img_width  (dst_img_width),
		.dst_img_height (dst_img_height)
	) u_stream (
		.clk        (clk),
		.rst_n      (rst_n),
		.window     (window),
		.empty      (fifo_empty),
		.rdata      (fifo_rdata),
		.rd         (fifo_rd),
		.tready     (m_axis_tready),
		.m_axis     (m_axis),
		.frame_done (frame_done)
	);

endmodule

/* upsp_ac.f */
src/ac_pkg.sv
src/ac_session_ctrl.sv
src/ac_out_fifo.sv
src/ac_stream_out.sv
src/access_control.sv
bench/tb_access_control.sv
